// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= calculator_tb
OBJ_DIR ?= obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' compile.f) hw/calc_config.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+hw
hw/calc_num_pkg.sv
hw/calc_ctrl_pkg.sv
hw/calc_addsub.sv
hw/calc_multiply.sv
hw/calc_entry_ctrl.sv
hw/calculator_top.sv
testbench/calculator_props.sv
testbench/calculator_checker.sv
testbench/calculator_tb.sv

// ==== hw/calc_addsub.sv ====
// Sign-magnitude add/subtract, finish one cycle after start, no overflow flag (magnitude wraps)
`timescale 1ns/10ps
`default_nettype none

`include "calc_config.svh"

module calc_addsub (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_num_pkg::calc_word_t a,
    input  calc_num_pkg::calc_word_t b,
    input  logic                   sub,
    input  logic                   start,
    output calc_num_pkg::calc_word_t result,
    output logic                   finish
);
    import calc_num_pkg::*;

    calc_mag_t a_mag;
    calc_mag_t b_mag;
    calc_mag_t sum_mag;
    logic      a_sign;
    logic      b_sign;
    logic      sum_sign;

    always_comb begin
        a_mag  = a[`CALC_MAG_WIDTH-1:0];
        b_mag  = b[`CALC_MAG_WIDTH-1:0];
        a_sign = a[`CALC_WIDTH-1];
        // Subtract is an add with b negated
        b_sign = b[`CALC_WIDTH-1] ^ sub;

        if (a_sign == b_sign) begin
            sum_mag  = a_mag + b_mag;
            sum_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            sum_mag  = a_mag - b_mag;
            sum_sign = a_sign;
        end else begin
            sum_mag  = b_mag - a_mag;
            sum_sign = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Held until the next start; zero is always positive
    always_ff @(posedge clk) begin
        if (start) begin
            result <= {sum_sign && (sum_mag != '0), sum_mag};
        end
    end

endmodule

`default_nettype wire

// ==== hw/calc_config.svh ====
// Widths are fixed for 16-bit sign-magnitude; the multiplier step count must equal the magnitude width
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// Sign bit plus magnitude
`define CALC_WIDTH 16
`define CALC_MAG_WIDTH 15

// Keypad entry is decimal
`define CALC_RADIX 10

// One conditional add per magnitude bit
`define CALC_MULT_STEPS 15

`endif

// ==== hw/calc_ctrl_pkg.sv ====
// Operator codes and entry FSM states; codes 5 to 7 are unused and ignored by the controller
`default_nettype none

package calc_ctrl_pkg;

    // Operator key code, zero means no key held
    typedef logic [2:0] calc_op_t;

    localparam calc_op_t OP_NONE   = 3'd0;
    localparam calc_op_t OP_NEGATE = 3'd1;
    localparam calc_op_t OP_ADD    = 3'd2;
    localparam calc_op_t OP_SUB    = 3'd3;
    localparam calc_op_t OP_MUL    = 3'd4;

    // Entry controller states
    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_DIGIT_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_DIGIT_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT
    } entry_state_t;

endpackage

`default_nettype wire

// ==== hw/calc_entry_ctrl.sv ====
// Keypad entry FSM; one held request at a time, drop it after key_read, no overflow or chaining
`timescale 1ns/10ps
`default_nettype none

`include "calc_config.svh"

module calc_entry_ctrl (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_num_pkg::calc_digit_t keypad_input,
    input  logic                     read_input,
    input  calc_ctrl_pkg::calc_op_t  operator_input,
    input  logic                     equal_input,
    input  calc_num_pkg::calc_word_t  alu_result,
    input  logic                     alu_finish,
    input  calc_num_pkg::calc_word_t  mult_result,
    input  logic                     mult_finish,
    output calc_num_pkg::calc_word_t  alu_a,
    output calc_num_pkg::calc_word_t  alu_b,
    output logic                     alu_sub,
    output logic                     alu_start,
    output calc_num_pkg::calc_word_t  mult_a,
    output calc_num_pkg::calc_word_t  mult_b,
    output logic                     mult_start,
    output logic                     key_read,
    output logic                     complete,
    output calc_num_pkg::calc_word_t  display_output
);
    import calc_num_pkg::*;
    import calc_ctrl_pkg::*;

    entry_state_t state;
    entry_state_t next_state;
    calc_word_t   operand1;
    calc_word_t   operand2;
    calc_digit_t  latched_digit;
    calc_op_t     latched_op;
    logic         use_mult;
    logic         entering;
    logic         idle;
    logic         digit_load;
    logic         neg_load;
    logic         op_load;
    logic         eq_load;
    logic         unit_finish;

    // Keep the sign, add the digit to the magnitude
    function automatic calc_word_t add_digit(input calc_word_t w, input calc_digit_t d);
        calc_mag_t mag;
        mag = w[`CALC_MAG_WIDTH-1:0] + calc_mag_t'(d);
        return {w[`CALC_WIDTH-1], mag};
    endfunction

    assign entering = (state == WAIT_OP1) || (state == WAIT_OP2);
    // Not while the previous request is still being acknowledged
    assign idle     = !key_read;

    assign digit_load  = entering && idle && read_input;
    assign neg_load    = entering && idle && !read_input && (operator_input == OP_NEGATE);
    assign op_load     = (state == WAIT_OP1) && idle && !read_input &&
                         ((operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                          (operator_input == OP_MUL));
    assign eq_load     = (state == WAIT_OP2) && idle && equal_input && !digit_load && !neg_load;
    assign unit_finish = use_mult ? mult_finish : alu_finish;

    always_comb begin
        next_state = state;
        case (state)
            WAIT_OP1: begin
                if (digit_load) begin
                    next_state = WAIT_MULT_OP1;
                end else if (op_load) begin
                    next_state = WAIT_OP2;
                end
            end
            WAIT_MULT_OP1:   next_state = mult_finish ? ADD_DIGIT_OP1 : WAIT_MULT_OP1;
            ADD_DIGIT_OP1:   next_state = WAIT_OP1;
            WAIT_OP2: begin
                if (digit_load) begin
                    next_state = WAIT_MULT_OP2;
                end else if (eq_load) begin
                    next_state = SEND_TO_COMPUTE;
                end
            end
            WAIT_MULT_OP2:   next_state = mult_finish ? ADD_DIGIT_OP2 : WAIT_MULT_OP2;
            ADD_DIGIT_OP2:   next_state = WAIT_OP2;
            SEND_TO_COMPUTE: next_state = WAIT_COMPUTE;
            WAIT_COMPUTE:    next_state = unit_finish ? SHOW_RESULT : WAIT_COMPUTE;
            default:         next_state = WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= WAIT_OP1;
            operand1       <= '0;
            operand2       <= '0;
            latched_op     <= OP_NONE;
            use_mult       <= 1'b0;
            key_read       <= 1'b0;
            complete       <= 1'b0;
            alu_start      <= 1'b0;
            mult_start     <= 1'b0;
            display_output <= '0;
        end else begin
            state      <= next_state;
            key_read   <= digit_load || neg_load || op_load || eq_load;
            complete   <= (state == SHOW_RESULT);
            mult_start <= digit_load || ((state == SEND_TO_COMPUTE) && (latched_op == OP_MUL));
            alu_start  <= (state == SEND_TO_COMPUTE) && (latched_op != OP_MUL);

            case (state)
                WAIT_OP1: begin
                    if (neg_load) begin
                        operand1[`CALC_WIDTH-1] <= 1'b1;
                    end
                    if (op_load) begin
                        latched_op <= operator_input;
                    end
                end
                // Only the magnitude comes back, a lone negate must survive a zero product
                WAIT_MULT_OP1: begin
                    if (mult_finish) begin
                        operand1 <= {operand1[`CALC_WIDTH-1], mult_result[`CALC_MAG_WIDTH-1:0]};
                    end
                end
                ADD_DIGIT_OP1: operand1 <= add_digit(operand1, latched_digit);
                WAIT_OP2: begin
                    if (neg_load) begin
                        operand2[`CALC_WIDTH-1] <= 1'b1;
                    end
                end
                WAIT_MULT_OP2: begin
                    if (mult_finish) begin
                        operand2 <= {operand2[`CALC_WIDTH-1], mult_result[`CALC_MAG_WIDTH-1:0]};
                    end
                end
                ADD_DIGIT_OP2: operand2 <= add_digit(operand2, latched_digit);
                SEND_TO_COMPUTE: use_mult <= (latched_op == OP_MUL);
                SHOW_RESULT: begin
                    display_output <= use_mult ? mult_result : alu_result;
                    operand1       <= '0;
                    operand2       <= '0;
                    latched_op     <= OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // Operand registers towards the units
    always_ff @(posedge clk) begin
        if (digit_load) begin
            latched_digit <= keypad_input;
            mult_a        <= (state == WAIT_OP2) ? operand2 : operand1;
            mult_b        <= calc_word_t'(`CALC_RADIX);
        end else if (state == SEND_TO_COMPUTE) begin
            alu_a   <= operand1;
            alu_b   <= operand2;
            alu_sub <= (latched_op == OP_SUB);
            mult_a  <= operand1;
            mult_b  <= operand2;
        end
    end

endmodule

`default_nettype wire

// ==== hw/calc_multiply.sv ====
// Shift-add sign-magnitude multiplier, finish CALC_MULT_STEPS+1 cycles after start; no restart while busy
`timescale 1ns/10ps
`default_nettype none

`include "calc_config.svh"

module calc_multiply (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_num_pkg::calc_word_t a,
    input  calc_num_pkg::calc_word_t b,
    input  logic                   start,
    output calc_num_pkg::calc_word_t result,
    output logic                   finish
);
    import calc_num_pkg::*;

    localparam int STEP_W = $clog2(`CALC_MULT_STEPS + 1);

    logic              busy;
    logic [STEP_W-1:0] steps_left;
    logic              last_step;
    logic              prod_sign;
    calc_mag_t         acc;
    calc_mag_t         acc_next;
    calc_mag_t         mcand;
    calc_mag_t         mplier;

    // Add the shifted multiplicand when the low multiplier bit is set
    assign acc_next  = mplier[0] ? calc_mag_t'(acc + mcand) : acc;
    assign last_step = busy && (steps_left == STEP_W'(1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            steps_left <= '0;
            finish     <= 1'b0;
        end else begin
            finish <= last_step;
            if (start) begin
                busy       <= 1'b1;
                steps_left <= STEP_W'(`CALC_MULT_STEPS);
            end else if (busy) begin
                steps_left <= steps_left - 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= '0;
            mcand     <= a[`CALC_MAG_WIDTH-1:0];
            mplier    <= b[`CALC_MAG_WIDTH-1:0];
            prod_sign <= a[`CALC_WIDTH-1] ^ b[`CALC_WIDTH-1];
        end else if (busy) begin
            acc    <= acc_next;
            // Bits shifted out the top are the modulo 2^15 wrap
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_step) begin
                result <= {prod_sign && (acc_next != '0), acc_next};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/calc_num_pkg.sv ====
// Number types for the calculator; bit 15 is the sign and magnitudes wrap modulo 2^15
`default_nettype none

`include "calc_config.svh"

package calc_num_pkg;

    // Sign-magnitude word, sign in the top bit
    typedef logic [`CALC_WIDTH-1:0] calc_word_t;

    // Magnitude part of a word
    typedef logic [`CALC_MAG_WIDTH-1:0] calc_mag_t;

    // One decimal keypad digit, values above 9 are not checked
    typedef logic [3:0] calc_digit_t;

endpackage

`default_nettype wire

// ==== hw/calculator_top.sv ====
// Calculator core; expects one held keypad request at a time and no division or chaining
`timescale 1ns/10ps
`default_nettype none

module calculator_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_num_pkg::calc_digit_t keypad_input,
    input  logic                     read_input,
    input  calc_ctrl_pkg::calc_op_t  operator_input,
    input  logic                     equal_input,
    output logic                     key_read,
    output logic                     complete,
    output calc_num_pkg::calc_word_t  display_output
);
    import calc_num_pkg::*;

    calc_word_t alu_a;
    calc_word_t alu_b;
    calc_word_t alu_result;
    logic       alu_sub;
    logic       alu_start;
    logic       alu_finish;
    calc_word_t mult_a;
    calc_word_t mult_b;
    calc_word_t mult_result;
    logic       mult_start;
    logic       mult_finish;

    calc_entry_ctrl i_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_sub        (alu_sub),
        .alu_start      (alu_start),
        .mult_a         (mult_a),
        .mult_b         (mult_b),
        .mult_start     (mult_start),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_addsub i_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .a      (alu_a),
        .b      (alu_b),
        .sub    (alu_sub),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    // Shared by digit entry and the multiply operator
    calc_multiply i_mult (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mult_a),
        .b      (mult_b),
        .start  (mult_start),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

`default_nettype wire

// ==== testbench/calculator_checker.sv ====
// Result checker; expects calc_sent before the keys of each calculation, operands of 1 to 3 digits
`timescale 1ns/10ps
`default_nettype none

`include "calc_config.svh"

module calculator_checker (
    input logic                     clk,
    input logic                     nRST,
    input logic                     complete,
    input calc_num_pkg::calc_word_t display_output,
    input logic                     calc_sent,
    input logic [11:0]              sent_d1,
    input logic [1:0]               sent_n1,
    input logic                     sent_neg1,
    input calc_ctrl_pkg::calc_op_t  sent_op,
    input logic [11:0]              sent_d2,
    input logic [1:0]               sent_n2,
    input logic                     sent_neg2
);
    import calc_num_pkg::*;
    import calc_ctrl_pkg::*;

    localparam int MAG_MOD = 1 << `CALC_MAG_WIDTH;
    localparam int COMPLETE_LIMIT = 150;

    int         test_count = 0;
    int         pass_count = 0;
    int         error_count = 0;
    int         wait_cycles = 0;
    logic       pending = 1'b0;
    logic       reset_checked = 1'b0;
    calc_word_t expected;

    // Decimal digits, most significant first, wrapped to the magnitude width
    function automatic int entry_mag(input logic [11:0] d, input logic [1:0] n);
        int m;
        m = 0;
        for (int i = int'(n) - 1; i >= 0; i--) begin
            m = (m * 10 + int'(d[i*4 +: 4])) % MAG_MOD;
        end
        return m;
    endfunction

    function automatic calc_word_t reference_result(
        input logic [11:0] d1, input logic [1:0] n1, input logic neg1,
        input calc_op_t op,
        input logic [11:0] d2, input logic [1:0] n2, input logic neg2);
        int   a;
        int   b;
        int   s;
        int   mag;
        logic sign;
        a = entry_mag(d1, n1);
        b = entry_mag(d2, n2);
        if (op == OP_MUL) begin
            mag  = (a * b) % MAG_MOD;
            sign = neg1 ^ neg2;
        end else begin
            if (neg1) a = -a;
            if (neg2) b = -b;
            s    = (op == OP_SUB) ? a - b : a + b;
            sign = (s < 0);
            mag  = ((s < 0) ? -s : s) % MAG_MOD;
        end
        // No negative zero
        if (mag == 0) sign = 1'b0;
        return {sign, calc_mag_t'(mag)};
    endfunction

    always @(negedge clk) begin
        if (nRST) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (display_output !== '0 || complete !== 1'b0) begin
                    $display("Error at %0t ns: display not zero or complete high after reset",
                             $time);
                    error_count++;
                end
            end
            if (calc_sent) begin
                expected = reference_result(sent_d1, sent_n1, sent_neg1, sent_op,
                                            sent_d2, sent_n2, sent_neg2);
                pending     = 1'b1;
                wait_cycles = 0;
                test_count++;
            end else if (complete) begin
                if (!pending) begin
                    $display("A complete pulse arrived with no calculation pending");
                    error_count++;
                end else if (display_output === expected) begin
                    $display("Test %0d passed: %h", test_count, display_output);
                    pass_count++;
                end else begin
                    $display("Error at %0t ns: test %0d expected %h, got %h",
                             $time, test_count, expected, display_output);
                    error_count++;
                end
                pending = 1'b0;
            end else if (pending) begin
                wait_cycles++;
                if (wait_cycles == COMPLETE_LIMIT) begin
                    $display("Test %0d failed: no complete within %0d cycles",
                             test_count, COMPLETE_LIMIT);
                    error_count++;
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/calculator_props.sv ====
// Handshake assertions for the entry FSM; attached by bind, state encoding comes from calc_ctrl_pkg
`timescale 1ns/10ps
`default_nettype none

module calculator_props (
    input logic clk,
    input logic nRST,
    input logic key_read,
    input logic complete,
    input logic alu_start,
    input logic mult_start,
    input logic alu_finish,
    input logic mult_finish
);

    a_key_read_pulse: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else $error("key_read lasted more than one cycle");

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete lasted more than one cycle");

    // Only one unit busy at a time
    a_one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mult_start))
        else $error("alu_start and mult_start together");

    // Finish, then SHOW_RESULT, then complete
    a_complete_after_finish: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> $past(alu_finish || mult_finish, 2))
        else $error("complete without a unit finish two cycles before");

endmodule

bind calc_entry_ctrl calculator_props i_props (
    .clk         (clk),
    .nRST        (nRST),
    .key_read    (key_read),
    .complete    (complete),
    .alu_start   (alu_start),
    .mult_start  (mult_start),
    .alu_finish  (alu_finish),
    .mult_finish (mult_finish)
);

`default_nettype wire

// ==== testbench/calculator_tb.sv ====
// Calculator testbench; 20 ns clock, inputs change 2 ns after the rising edge, LFSR seed 35
`timescale 1ns/10ps
`default_nettype none

module calculator_tb;
    import calc_num_pkg::*;
    import calc_ctrl_pkg::*;

    localparam int N_TESTS = 212;
    localparam int MAX_KEYS = 10;

    logic        clk;
    logic        nRST;
    calc_digit_t keypad_input;
    logic        read_input;
    calc_op_t    operator_input;
    logic        equal_input;
    logic        key_read;
    logic        complete;
    calc_word_t  display_output;

    logic        calc_sent;
    logic [11:0] sent_d1;
    logic [11:0] sent_d2;
    logic [1:0]  sent_n1;
    logic [1:0]  sent_n2;
    logic        sent_neg1;
    logic        sent_neg2;
    calc_op_t    sent_op;
    logic [15:0] lfsr = 16'd35;
    int          key_errors = 0;
    int          total_errors;

    calculator_top i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    calculator_checker i_check (
        .clk            (clk),
        .nRST           (nRST),
        .complete       (complete),
        .display_output (display_output),
        .calc_sent      (calc_sent),
        .sent_d1        (sent_d1),
        .sent_n1        (sent_n1),
        .sent_neg1      (sent_neg1),
        .sent_op        (sent_op),
        .sent_d2        (sent_d2),
        .sent_n2        (sent_n2),
        .sent_neg2      (sent_neg2)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic send_key(input logic is_digit, input calc_digit_t d, input calc_op_t op,
                            input logic eq);
        int waited;
        keypad_input   = d;
        read_input     = is_digit;
        operator_input = op;
        equal_input    = eq;
        waited = 0;
        @(negedge clk);
        while (key_read !== 1'b1 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (key_read !== 1'b1) begin
            $display("A held key was never acknowledged at %0t ns", $time);
            key_errors++;
        end
        @(posedge clk);
        #2;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
    endtask

    // Request the FSM cannot use in its current state, so no acknowledge
    task automatic hold_ignored(input calc_op_t op, input logic eq, input int cycles);
        operator_input = op;
        equal_input    = eq;
        repeat (cycles) begin
            @(posedge clk);
            #2;
            if (key_read === 1'b1) begin
                $display("An ignored key was acknowledged at %0t ns", $time);
                key_errors++;
            end
        end
        operator_input = OP_NONE;
        equal_input    = 1'b0;
    endtask

    task automatic enter_operand(input logic [11:0] d, input int n, input logic neg);
        for (int i = n - 1; i >= 0; i--) begin
            send_key(1'b1, d[i*4 +: 4], OP_NONE, 1'b0);
        end
        if (neg) begin
            send_key(1'b0, '0, OP_NEGATE, 1'b0);
        end
    endtask

    // Optional noise holds a negate while computing and an equals while idle
    task automatic calculate(input logic [11:0] d1, input int n1, input logic neg1,
                             input calc_op_t op, input logic [11:0] d2, input int n2,
                             input logic neg2, input logic noise);
        int waited;
        sent_d1   = d1;
        sent_n1   = 2'(n1);
        sent_neg1 = neg1;
        sent_op   = op;
        sent_d2   = d2;
        sent_n2   = 2'(n2);
        sent_neg2 = neg2;
        calc_sent = 1'b1;
        @(posedge clk);
        #2;
        calc_sent = 1'b0;
        enter_operand(d1, n1, neg1);
        send_key(1'b0, '0, op, 1'b0);
        enter_operand(d2, n2, neg2);
        send_key(1'b0, '0, OP_NONE, 1'b1);
        if (noise) begin
            hold_ignored(OP_NEGATE, 1'b0, 1);
        end
        waited = 0;
        while (complete !== 1'b1 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #2;
        if (noise) begin
            hold_ignored(OP_NONE, 1'b1, 4);
        end
    endtask

    task automatic random_operand(output logic [11:0] d, output int n, output logic neg);
        int v;
        take_bits(2, v);
        n = 1 + v % 3;
        d = '0;
        for (int i = 0; i < n; i++) begin
            take_bits(4, v);
            d[i*4 +: 4] = calc_digit_t'(v % 10);
        end
        take_bits(1, v);
        neg = v[0];
    endtask

    task automatic random_calc();
        logic [11:0] d1;
        logic [11:0] d2;
        int          n1;
        int          n2;
        int          v;
        logic        neg1;
        logic        neg2;
        calc_op_t    op;
        random_operand(d1, n1, neg1);
        take_bits(2, v);
        case (v % 3)
            0:       op = OP_ADD;
            1:       op = OP_SUB;
            default: op = OP_MUL;
        endcase
        random_operand(d2, n2, neg2);
        calculate(d1, n1, neg1, op, d2, n2, neg2, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * (MAX_KEYS * 40 + 40)) @(posedge clk);
        $display("The run timed out before all tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        calc_sent      = 1'b0;
        sent_d1        = '0;
        sent_d2        = '0;
        sent_n1        = '0;
        sent_n2        = '0;
        sent_neg1      = 1'b0;
        sent_neg2      = 1'b0;
        sent_op        = OP_NONE;
        repeat (4) @(posedge clk);
        #2;
        nRST = 1'b1;

        calculate(12'h123, 3, 1'b0, OP_ADD, 12'h045, 2, 1'b0, 1'b0);
        // Signed subtraction, down to an exact zero
        calculate(12'h012, 2, 1'b0, OP_SUB, 12'h345, 3, 1'b0, 1'b0);
        calculate(12'h025, 2, 1'b1, OP_SUB, 12'h025, 2, 1'b1, 1'b0);
        calculate(12'h007, 1, 1'b1, OP_SUB, 12'h030, 2, 1'b0, 1'b0);
        calculate(12'h012, 2, 1'b1, OP_MUL, 12'h034, 2, 1'b0, 1'b0);
        calculate(12'h000, 1, 1'b0, OP_MUL, 12'h056, 2, 1'b1, 1'b0);
        calculate(12'h009, 1, 1'b1, OP_MUL, 12'h009, 1, 1'b1, 1'b0);
        // Products past 2^15 wrap
        calculate(12'h999, 3, 1'b0, OP_MUL, 12'h099, 2, 1'b0, 1'b0);
        calculate(12'h999, 3, 1'b1, OP_MUL, 12'h999, 3, 1'b0, 1'b0);
        calculate(12'h005, 1, 1'b0, OP_ADD, 12'h006, 1, 1'b0, 1'b1);
        calculate(12'h007, 1, 1'b0, OP_MUL, 12'h008, 1, 1'b0, 1'b1);
        calculate(12'h001, 1, 1'b0, OP_SUB, 12'h001, 1, 1'b0, 1'b0);
        repeat (200) random_calc();

        repeat (4) @(posedge clk);
        total_errors = i_check.error_count + key_errors;
        $display("Tests run: %0d, passed: %0d, errors: %0d",
                 i_check.test_count, i_check.pass_count, total_errors);
        if (total_errors == 0 && i_check.test_count == N_TESTS) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
